// File: design/moxie_exec_pkg.sv
// Shared definitions for the reduced moxie execute stage
// Value widths, opcode codes, byte selects and CMP flag layout

package moxie_exec_pkg;

  typedef logic [31:0] word_t;
  typedef logic [15:0] half_t;
  typedef logic [3:0]  reg_index_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [9:0]  pcrel_t;
  typedef logic [1:0]  sel_t;
  typedef logic [4:0]  cc_t;

  // Byte lanes on the 16-bit data bus
  localparam sel_t sel_byte = 2'b01;
  localparam sel_t sel_half = 2'b11;

  // Flag positions in the CMP result
  localparam int cc_eq_bit  = 0;
  localparam int cc_lt_bit  = 1;
  localparam int cc_gt_bit  = 2;
  localparam int cc_ltu_bit = 3;
  localparam int cc_gtu_bit = 4;

  // Register result ops
  localparam opcode_t op_ldi_l = 7'h01;
  localparam opcode_t op_mov   = 7'h02;
  localparam opcode_t op_add_l = 7'h05;
  localparam opcode_t op_sex_b = 7'h10;
  localparam opcode_t op_sex_s = 7'h11;
  localparam opcode_t op_zex_b = 7'h12;
  localparam opcode_t op_zex_s = 7'h13;
  localparam opcode_t op_and   = 7'h26;
  localparam opcode_t op_lshr  = 7'h27;
  localparam opcode_t op_ashl  = 7'h28;
  localparam opcode_t op_sub_l = 7'h29;
  localparam opcode_t op_neg   = 7'h2a;
  localparam opcode_t op_or    = 7'h2b;
  localparam opcode_t op_not   = 7'h2c;
  localparam opcode_t op_ashr  = 7'h2d;
  localparam opcode_t op_xor   = 7'h2e;
  localparam opcode_t op_inc   = 7'h30;
  localparam opcode_t op_dec   = 7'h31;

  // Compare and control flow
  localparam opcode_t op_cmp   = 7'h0e;
  localparam opcode_t op_jmpa  = 7'h1a;
  localparam opcode_t op_jmp   = 7'h25;
  localparam opcode_t op_beq   = 7'h40;
  localparam opcode_t op_bne   = 7'h41;
  localparam opcode_t op_blt   = 7'h42;
  localparam opcode_t op_bgt   = 7'h43;
  localparam opcode_t op_bltu  = 7'h44;
  localparam opcode_t op_bgtu  = 7'h45;
  localparam opcode_t op_bge   = 7'h46;
  localparam opcode_t op_ble   = 7'h47;
  localparam opcode_t op_bgeu  = 7'h48;
  localparam opcode_t op_bleu  = 7'h49;

  // Stores
  localparam opcode_t op_sta_l = 7'h09;
  localparam opcode_t op_st_l  = 7'h0b;
  localparam opcode_t op_sto_l = 7'h0d;
  localparam opcode_t op_st_b  = 7'h1e;
  localparam opcode_t op_sta_b = 7'h1f;
  localparam opcode_t op_st_s  = 7'h23;
  localparam opcode_t op_sta_s = 7'h24;
  localparam opcode_t op_sto_b = 7'h37;
  localparam opcode_t op_sto_s = 7'h39;

endpackage

// File: design/exec_alu.sv
// Moxie execute producer
// Runs ALU, CMP and branch ops and turns stores into halfword write requests

`timescale 1ns/10ps

module exec_alu (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        issue_i,
  input  moxie_exec_pkg::opcode_t     op_i,
  input  moxie_exec_pkg::word_t       reg_a_i,
  input  moxie_exec_pkg::word_t       reg_b_i,
  input  moxie_exec_pkg::word_t       operand_i,
  input  moxie_exec_pkg::word_t       pc_i,
  input  moxie_exec_pkg::pcrel_t      pcrel_offset_i,
  input  moxie_exec_pkg::reg_index_t  wr_index_i,
  input  logic                        room_i,
  output logic                        stall_o,
  output logic                        reg_we_o,
  output moxie_exec_pkg::reg_index_t  reg_index_o,
  output moxie_exec_pkg::word_t       reg_result_o,
  output logic                        branch_flag_o,
  output moxie_exec_pkg::word_t       branch_target_o,
  output logic                        push_o,
  output moxie_exec_pkg::word_t       push_addr_o,
  output moxie_exec_pkg::half_t       push_data_o,
  output moxie_exec_pkg::sel_t        push_sel_o
);

  import moxie_exec_pkg::*;

  logic  go;
  logic  alu_hit;
  word_t alu_res;
  word_t incdec;
  logic  br_hit;
  word_t br_target;
  word_t pcrel_target;
  cc_t   cc_q;
  cc_t   cc_next;
  logic  st_byte;
  logic  st_short;
  logic  st_long;
  logic  st_hit;
  logic  st_abs;
  logic  st_off;
  word_t st_addr;
  word_t st_src;
  half_t st_first;
  sel_t  st_sel;
  logic  low_pending_q;
  word_t low_addr_q;
  half_t low_data_q;

  // Squash anything arriving right behind a taken branch
  assign go = issue_i && !stall_o && !branch_flag_o;

  // Hold stores while a push is in flight or the queue is short of two slots
  assign stall_o = issue_i && st_hit && (!room_i || push_o);

  assign incdec       = {24'b0, pcrel_offset_i[7:0]};
  assign pcrel_target = {{21{pcrel_offset_i[9]}}, pcrel_offset_i, 1'b0} + pc_i + 32'd2;

  assign cc_next[cc_eq_bit]  = reg_a_i == reg_b_i;
  assign cc_next[cc_lt_bit]  = $signed(reg_a_i) < $signed(reg_b_i);
  assign cc_next[cc_gt_bit]  = $signed(reg_a_i) > $signed(reg_b_i);
  assign cc_next[cc_ltu_bit] = reg_a_i < reg_b_i;
  assign cc_next[cc_gtu_bit] = reg_a_i > reg_b_i;

  always_comb
  begin
    alu_hit = 1'b1;
    alu_res = '0;
    case (op_i)
      op_add_l: alu_res = reg_a_i + reg_b_i;
      op_sub_l: alu_res = reg_a_i - reg_b_i;
      op_and:   alu_res = reg_a_i & reg_b_i;
      op_or:    alu_res = reg_a_i | reg_b_i;
      op_xor:   alu_res = reg_a_i ^ reg_b_i;
      op_ashl:  alu_res = reg_a_i << reg_b_i[4:0];
      op_ashr:  alu_res = word_t'($signed(reg_a_i) >>> reg_b_i[4:0]);
      op_lshr:  alu_res = reg_a_i >> reg_b_i[4:0];
      op_mov:   alu_res = reg_b_i;
      op_not:   alu_res = ~reg_b_i;
      op_neg:   alu_res = -reg_b_i;
      op_inc:   alu_res = reg_a_i + incdec;
      op_dec:   alu_res = reg_a_i - incdec;
      op_sex_b: alu_res = {{24{reg_b_i[7]}}, reg_b_i[7:0]};
      op_sex_s: alu_res = {{16{reg_b_i[15]}}, reg_b_i[15:0]};
      op_zex_b: alu_res = {24'b0, reg_b_i[7:0]};
      op_zex_s: alu_res = {16'b0, reg_b_i[15:0]};
      op_ldi_l: alu_res = operand_i;
      default:  alu_hit = 1'b0;
    endcase
  end

  // Conditions come from the stored flags, not the current operands
  always_comb
  begin
    br_hit    = 1'b1;
    br_target = pcrel_target;
    case (op_i)
      op_beq:  br_hit = cc_q[cc_eq_bit];
      op_bne:  br_hit = !cc_q[cc_eq_bit];
      op_blt:  br_hit = cc_q[cc_lt_bit];
      op_bgt:  br_hit = cc_q[cc_gt_bit];
      op_bltu: br_hit = cc_q[cc_ltu_bit];
      op_bgtu: br_hit = cc_q[cc_gtu_bit];
      op_ble:  br_hit = cc_q[cc_eq_bit] || cc_q[cc_lt_bit];
      op_bge:  br_hit = cc_q[cc_eq_bit] || cc_q[cc_gt_bit];
      op_bleu: br_hit = cc_q[cc_eq_bit] || cc_q[cc_ltu_bit];
      op_bgeu: br_hit = cc_q[cc_eq_bit] || cc_q[cc_gtu_bit];
      op_jmp:  br_target = reg_a_i;
      op_jmpa: br_target = operand_i;
      default: br_hit = 1'b0;
    endcase
  end

  assign st_byte  = op_i inside {op_st_b, op_sta_b, op_sto_b};
  assign st_short = op_i inside {op_st_s, op_sta_s, op_sto_s};
  assign st_long  = op_i inside {op_st_l, op_sta_l, op_sto_l};
  assign st_abs   = op_i inside {op_sta_b, op_sta_s, op_sta_l};
  assign st_off   = op_i inside {op_sto_b, op_sto_s, op_sto_l};
  assign st_hit   = st_byte || st_short || st_long;

  assign st_addr  = st_abs ? operand_i : (st_off ? operand_i + reg_a_i : reg_a_i);
  assign st_src   = st_abs ? reg_a_i : reg_b_i;
  // Long stores go out high half first
  assign st_first = st_long ? st_src[31:16] : (st_byte ? {8'h00, st_src[7:0]} : st_src[15:0]);
  assign st_sel   = st_byte ? sel_byte : sel_half;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      reg_we_o      <= 1'b0;
      branch_flag_o <= 1'b0;
      cc_q          <= '0;
      push_o        <= 1'b0;
      low_pending_q <= 1'b0;
    end
    else
    begin
      reg_we_o      <= go && alu_hit;
      branch_flag_o <= go && br_hit;
      if (go && op_i == op_cmp)
        cc_q <= cc_next;
      push_o        <= (go && st_hit) || low_pending_q;
      low_pending_q <= go && st_long;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (go)
    begin
      reg_index_o     <= wr_index_i;
      reg_result_o    <= alu_res;
      branch_target_o <= br_target;
    end
    if (go && st_hit)
    begin
      push_addr_o <= st_addr;
      push_data_o <= st_first;
      push_sel_o  <= st_sel;
      low_addr_q  <= st_addr + 32'd2;
      low_data_q  <= st_src[15:0];
    end
    else if (low_pending_q)
    begin
      push_addr_o <= low_addr_q;
      push_data_o <= low_data_q;
      push_sel_o  <= sel_half;
    end
  end

endmodule

// File: design/store_queue.sv
// Store queue
// Circular FIFO of pending halfword writes between execute and the data bus

`timescale 1ns/10ps

module store_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   push_i,
  input  moxie_exec_pkg::word_t  push_addr_i,
  input  moxie_exec_pkg::half_t  push_data_i,
  input  moxie_exec_pkg::sel_t   push_sel_i,
  input  logic                   pop_i,
  output logic                   room_o,
  output logic                   not_empty_o,
  output moxie_exec_pkg::word_t  head_addr_o,
  output moxie_exec_pkg::half_t  head_data_o,
  output moxie_exec_pkg::sel_t   head_sel_o
);

  import moxie_exec_pkg::*;

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  // Highest occupancy that still leaves two free slots
  localparam logic [PTR_W:0] ROOM_LIMIT = (PTR_W + 1)'(QUEUE_DEPTH - 2);

  word_t            addr_mem [QUEUE_DEPTH];
  half_t            data_mem [QUEUE_DEPTH];
  sel_t             sel_mem  [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop_i)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push_i)
    begin
      addr_mem[wr_ptr] <= push_addr_i;
      data_mem[wr_ptr] <= push_data_i;
      sel_mem[wr_ptr]  <= push_sel_i;
    end
  end

  assign room_o      = count <= ROOM_LIMIT;
  assign not_empty_o = count != '0;
  assign head_addr_o = addr_mem[rd_ptr];
  assign head_data_o = data_mem[rd_ptr];
  assign head_sel_o  = sel_mem[rd_ptr];

endmodule

// File: design/dmem_master.sv
// Data bus master
// Takes halfword writes from the store queue and holds each one until ack

`timescale 1ns/10ps

module dmem_master (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   not_empty_i,
  input  moxie_exec_pkg::word_t  head_addr_i,
  input  moxie_exec_pkg::half_t  head_data_i,
  input  moxie_exec_pkg::sel_t   head_sel_i,
  input  logic                   dmem_ack_i,
  output logic                   pop_o,
  output logic                   dmem_cyc_o,
  output logic                   dmem_stb_o,
  output logic                   dmem_we_o,
  output moxie_exec_pkg::sel_t   dmem_sel_o,
  output moxie_exec_pkg::word_t  dmem_address_o,
  output moxie_exec_pkg::half_t  dmem_data_o
);

  typedef enum logic {
    bus_idle,
    bus_write
  } bus_state_t;

  bus_state_t state_q;

  assign pop_o = (state_q == bus_idle) && not_empty_i;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q    <= bus_idle;
      dmem_stb_o <= 1'b0;
      dmem_cyc_o <= 1'b0;
      dmem_we_o  <= 1'b0;
    end
    else
    begin
      case (state_q)
        bus_idle:
        begin
          if (not_empty_i)
          begin
            state_q    <= bus_write;
            dmem_stb_o <= 1'b1;
            dmem_cyc_o <= 1'b1;
            dmem_we_o  <= 1'b1;
          end
        end
        bus_write:
        begin
          // Fields stay put until the slave answers
          if (dmem_ack_i)
          begin
            state_q    <= bus_idle;
            dmem_stb_o <= 1'b0;
            dmem_cyc_o <= 1'b0;
            dmem_we_o  <= 1'b0;
          end
        end
        default: state_q <= bus_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (pop_o)
    begin
      dmem_address_o <= head_addr_i;
      dmem_data_o    <= head_data_i;
      dmem_sel_o     <= head_sel_i;
    end
  end

endmodule

// File: design/moxie_execute.sv
// Reduced moxie execute stage
// Producer, store queue and data bus master wired together

`timescale 1ns/10ps

module moxie_execute #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        issue_i,
  input  moxie_exec_pkg::opcode_t     op_i,
  input  moxie_exec_pkg::word_t       reg_a_i,
  input  moxie_exec_pkg::word_t       reg_b_i,
  input  moxie_exec_pkg::word_t       operand_i,
  input  moxie_exec_pkg::pcrel_t      pcrel_offset_i,
  input  moxie_exec_pkg::word_t       pc_i,
  input  moxie_exec_pkg::reg_index_t  wr_index_i,
  output logic                        stall_o,
  output logic                        reg_we_o,
  output moxie_exec_pkg::reg_index_t  reg_index_o,
  output moxie_exec_pkg::word_t       reg_result_o,
  output logic                        branch_flag_o,
  output moxie_exec_pkg::word_t       branch_target_o,
  output logic                        dmem_cyc_o,
  output logic                        dmem_stb_o,
  output logic                        dmem_we_o,
  output moxie_exec_pkg::sel_t        dmem_sel_o,
  output moxie_exec_pkg::word_t       dmem_address_o,
  output moxie_exec_pkg::half_t       dmem_data_o,
  input  logic                        dmem_ack_i
);

  import moxie_exec_pkg::*;

  logic  room;
  logic  push;
  word_t push_addr;
  half_t push_data;
  sel_t  push_sel;
  logic  pop;
  logic  not_empty;
  word_t head_addr;
  half_t head_data;
  sel_t  head_sel;

  exec_alu u_exec_alu (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .issue_i         (issue_i),
    .op_i            (op_i),
    .reg_a_i         (reg_a_i),
    .reg_b_i         (reg_b_i),
    .operand_i       (operand_i),
    .pc_i            (pc_i),
    .pcrel_offset_i  (pcrel_offset_i),
    .wr_index_i      (wr_index_i),
    .room_i          (room),
    .stall_o         (stall_o),
    .reg_we_o        (reg_we_o),
    .reg_index_o     (reg_index_o),
    .reg_result_o    (reg_result_o),
    .branch_flag_o   (branch_flag_o),
    .branch_target_o (branch_target_o),
    .push_o          (push),
    .push_addr_o     (push_addr),
    .push_data_o     (push_data),
    .push_sel_o      (push_sel)
  );

  store_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_store_queue (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .push_i      (push),
    .push_addr_i (push_addr),
    .push_data_i (push_data),
    .push_sel_i  (push_sel),
    .pop_i       (pop),
    .room_o      (room),
    .not_empty_o (not_empty),
    .head_addr_o (head_addr),
    .head_data_o (head_data),
    .head_sel_o  (head_sel)
  );

  dmem_master u_dmem_master (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .not_empty_i    (not_empty),
    .head_addr_i    (head_addr),
    .head_data_i    (head_data),
    .head_sel_i     (head_sel),
    .dmem_ack_i     (dmem_ack_i),
    .pop_o          (pop),
    .dmem_cyc_o     (dmem_cyc_o),
    .dmem_stb_o     (dmem_stb_o),
    .dmem_we_o      (dmem_we_o),
    .dmem_sel_o     (dmem_sel_o),
    .dmem_address_o (dmem_address_o),
    .dmem_data_o    (dmem_data_o)
  );

endmodule

// File: tests/moxie_execute_assertions.sv
// Concurrent checks for the moxie execute stage
// Models ALU results, CMP flags, branches and the expected data bus writes

`timescale 1ns/10ps

module moxie_execute_assertions (
  input logic                        clk_i,
  input logic                        rst_i,
  input logic                        issue_i,
  input moxie_exec_pkg::opcode_t     op_i,
  input moxie_exec_pkg::word_t       reg_a_i,
  input moxie_exec_pkg::word_t       reg_b_i,
  input moxie_exec_pkg::word_t       operand_i,
  input moxie_exec_pkg::pcrel_t      pcrel_offset_i,
  input moxie_exec_pkg::word_t       pc_i,
  input moxie_exec_pkg::reg_index_t  wr_index_i,
  input logic                        stall_o,
  input logic                        reg_we_o,
  input moxie_exec_pkg::reg_index_t  reg_index_o,
  input moxie_exec_pkg::word_t       reg_result_o,
  input logic                        branch_flag_o,
  input moxie_exec_pkg::word_t       branch_target_o,
  input logic                        dmem_cyc_o,
  input logic                        dmem_stb_o,
  input logic                        dmem_we_o,
  input moxie_exec_pkg::sel_t        dmem_sel_o,
  input moxie_exec_pkg::word_t       dmem_address_o,
  input moxie_exec_pkg::half_t       dmem_data_o,
  input logic                        dmem_ack_i
);

  import moxie_exec_pkg::*;

  bit    failed = 1'b0;
  logic  live;
  logic  seen_accept_q;
  cc_t   cc_model_q;
  logic  exp_we;
  word_t exp_result;
  logic  exp_taken;
  word_t exp_target;
  word_t exp_addr [$];
  half_t exp_data [$];
  sel_t  exp_sel [$];
  int    exp_count_q;
  word_t head_addr_q;
  half_t head_data_q;
  sel_t  head_sel_q;

  function automatic logic is_alu(input opcode_t op);
    return op inside {op_add_l, op_sub_l, op_and, op_or, op_xor, op_ashl, op_ashr,
                      op_lshr, op_mov, op_not, op_neg, op_inc, op_dec, op_sex_b,
                      op_sex_s, op_zex_b, op_zex_s, op_ldi_l};
  endfunction

  function automatic word_t alu_model(input opcode_t op, input word_t a, input word_t b,
                                      input word_t imm, input pcrel_t off);
    case (op)
      op_add_l: return a + b;
      op_sub_l: return a - b;
      op_and:   return a & b;
      op_or:    return a | b;
      op_xor:   return a ^ b;
      op_ashl:  return a << b[4:0];
      op_ashr:  return word_t'($signed(a) >>> b[4:0]);
      op_lshr:  return a >> b[4:0];
      op_mov:   return b;
      op_not:   return ~b;
      op_neg:   return 32'd0 - b;
      // INC and DEC carry an 8-bit immediate
      op_inc:   return a + word_t'(off[7:0]);
      op_dec:   return a - word_t'(off[7:0]);
      op_sex_b: return word_t'($signed(b[7:0]));
      op_sex_s: return word_t'($signed(b[15:0]));
      op_zex_b: return word_t'(b[7:0]);
      op_zex_s: return word_t'(b[15:0]);
      op_ldi_l: return imm;
      default:  return '0;
    endcase
  endfunction

  function automatic logic branch_taken(input opcode_t op, input cc_t cc);
    case (op)
      op_beq:          return cc[cc_eq_bit];
      op_bne:          return !cc[cc_eq_bit];
      op_blt:          return cc[cc_lt_bit];
      op_bgt:          return cc[cc_gt_bit];
      op_bltu:         return cc[cc_ltu_bit];
      op_bgtu:         return cc[cc_gtu_bit];
      op_ble:          return cc[cc_lt_bit] || cc[cc_eq_bit];
      op_bge:          return cc[cc_gt_bit] || cc[cc_eq_bit];
      op_bleu:         return cc[cc_ltu_bit] || cc[cc_eq_bit];
      op_bgeu:         return cc[cc_gtu_bit] || cc[cc_eq_bit];
      op_jmp, op_jmpa: return 1'b1;
      default:         return 1'b0;
    endcase
  endfunction

  task automatic expect_write(input word_t addr, input half_t data, input sel_t sel);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_sel.push_back(sel);
  endtask

  assign live       = issue_i && !stall_o && !branch_flag_o;
  assign exp_we     = live && is_alu(op_i);
  assign exp_result = alu_model(op_i, reg_a_i, reg_b_i, operand_i, pcrel_offset_i);
  assign exp_taken  = live && branch_taken(op_i, cc_model_q);
  assign exp_target = (op_i == op_jmp) ? reg_a_i :
                      (op_i == op_jmpa) ? operand_i :
                      pc_i + 32'd2 + ({{22{pcrel_offset_i[9]}}, pcrel_offset_i} << 1);

  always @(posedge clk_i or posedge rst_i)
  begin
    word_t base;
    word_t src;
    base = op_i inside {op_sta_b, op_sta_s, op_sta_l} ? operand_i :
           op_i inside {op_sto_b, op_sto_s, op_sto_l} ? operand_i + reg_a_i : reg_a_i;
    src  = op_i inside {op_sta_b, op_sta_s, op_sta_l} ? reg_a_i : reg_b_i;
    if (rst_i)
    begin
      exp_addr.delete();
      exp_data.delete();
      exp_sel.delete();
      exp_count_q   <= 0;
      seen_accept_q <= 1'b0;
      cc_model_q    <= '0;
    end
    else
    begin
      if (issue_i && !stall_o)
        seen_accept_q <= 1'b1;
      if (live && op_i == op_cmp)
      begin
        cc_model_q[cc_eq_bit]  <= reg_a_i == reg_b_i;
        cc_model_q[cc_lt_bit]  <= $signed(reg_a_i) < $signed(reg_b_i);
        cc_model_q[cc_gt_bit]  <= $signed(reg_a_i) > $signed(reg_b_i);
        cc_model_q[cc_ltu_bit] <= reg_a_i < reg_b_i;
        cc_model_q[cc_gtu_bit] <= reg_a_i > reg_b_i;
      end
      if (dmem_stb_o && dmem_ack_i && exp_addr.size() != 0)
      begin
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
        void'(exp_sel.pop_front());
      end
      if (live && op_i inside {op_st_b, op_sta_b, op_sto_b})
        expect_write(base, {8'h00, src[7:0]}, sel_byte);
      if (live && op_i inside {op_st_s, op_sta_s, op_sto_s})
        expect_write(base, src[15:0], sel_half);
      // Long stores: high half at the base, low half two bytes up
      if (live && op_i inside {op_st_l, op_sta_l, op_sto_l})
      begin
        expect_write(base, src[31:16], sel_half);
        expect_write(base + 32'd2, src[15:0], sel_half);
      end
      exp_count_q <= exp_addr.size();
      if (exp_addr.size() != 0)
      begin
        head_addr_q <= exp_addr[0];
        head_data_q <= exp_data[0];
        head_sel_q  <= exp_sel[0];
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
    !seen_accept_q |-> !(dmem_stb_o || dmem_cyc_o || dmem_we_o || reg_we_o
                         || branch_flag_o || stall_o))
  else
  begin
    failed = 1'b1;
    $error("CHECK FAILED at %0t: outputs active before the first instruction", $time);
  end

  a_reg_we: assert property (@(posedge clk_i) disable iff (rst_i)
    reg_we_o == $past(exp_we))
  else
  begin
    failed = 1'b1;
    $error("CHECK FAILED at %0t: reg_we_o is %0b", $time, reg_we_o);
  end

  a_reg_result: assert property (@(posedge clk_i) disable iff (rst_i)
    reg_we_o |-> reg_index_o == $past(wr_index_i) && reg_result_o == $past(exp_result))
  else
  begin
    failed = 1'b1;
    $error("CHECK FAILED at %0t: r%0d result %h", $time, reg_index_o, reg_result_o);
  end

  a_branch_flag: assert property (@(posedge clk_i) disable iff (rst_i)
    branch_flag_o == $past(exp_taken))
  else
  begin
    failed = 1'b1;
    $error("CHECK FAILED at %0t: branch_flag_o is %0b", $time, branch_flag_o);
  end

  a_branch_target: assert property (@(posedge clk_i) disable iff (rst_i)
    branch_flag_o |-> branch_target_o == $past(exp_target))
  else
  begin
    failed = 1'b1;
    $error("CHECK FAILED at %0t: branch target %h", $time, branch_target_o);
  end

  a_bus_strobes: assert property (@(posedge clk_i) disable iff (rst_i)
    dmem_cyc_o == dmem_stb_o && dmem_we_o == dmem_stb_o)
  else
  begin
    failed = 1'b1;
    $error("CHECK FAILED at %0t: stb, cyc and we disagree", $time);
  end

  a_bus_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    dmem_stb_o && !dmem_ack_i |=> dmem_stb_o && $stable(dmem_address_o)
                                  && $stable(dmem_data_o) && $stable(dmem_sel_o))
  else
  begin
    failed = 1'b1;
    $error("CHECK FAILED at %0t: write dropped or changed before ack", $time);
  end

  a_write_expected: assert property (@(posedge clk_i) disable iff (rst_i)
    dmem_stb_o |-> exp_count_q != 0)
  else
  begin
    failed = 1'b1;
    $error("CHECK FAILED at %0t: bus write %h with none expected", $time, dmem_address_o);
  end

  a_write_match: assert property (@(posedge clk_i) disable iff (rst_i)
    dmem_stb_o && dmem_ack_i |-> dmem_address_o == head_addr_q
                                 && dmem_data_o == head_data_q && dmem_sel_o == head_sel_q)
  else
  begin
    failed = 1'b1;
    $error("CHECK FAILED at %0t: write %h/%h/%b, expected %h/%h/%b", $time, dmem_address_o,
           dmem_data_o, dmem_sel_o, head_addr_q, head_data_q, head_sel_q);
  end

endmodule

bind moxie_execute moxie_execute_assertions u_checks (.*);

// File: tests/moxie_execute_tb.sv
// Testbench for the reduced moxie execute stage
// LFSR driven instruction stream and a data bus responder with random ack delay

`timescale 1ns/10ps

module moxie_execute_tb;

  import moxie_exec_pkg::*;

  localparam int N_RANDOM       = 300;
  localparam int N_HOLD_STORES  = 30;
  localparam int N_INSTR        = N_RANDOM + N_HOLD_STORES;
  // Two halfword writes of up to five wait cycles plus bus overhead
  localparam int STORE_CYCLES   = 16;
  localparam int TIMEOUT_CYCLES = 2 * N_INSTR * STORE_CYCLES;
  localparam int HOLD_CYCLES    = 20;

  // ALU 0 to 17, CMP 18, branches 19 to 30, stores 31 to 39
  localparam opcode_t OP_TABLE [40] = '{
    op_add_l, op_sub_l, op_and, op_or, op_xor, op_ashl, op_ashr, op_lshr, op_mov,
    op_not, op_neg, op_inc, op_dec, op_sex_b, op_sex_s, op_zex_b, op_zex_s, op_ldi_l,
    op_cmp, op_beq, op_bne, op_blt, op_bgt, op_bltu, op_bgtu, op_bge, op_ble, op_bgeu,
    op_bleu, op_jmp, op_jmpa, op_st_b, op_sta_b, op_sto_b, op_st_s, op_sta_s, op_sto_s,
    op_st_l, op_sta_l, op_sto_l
  };

  logic       clk_i;
  logic       rst_i;
  logic       issue_i;
  opcode_t    op_i;
  word_t      reg_a_i;
  word_t      reg_b_i;
  word_t      operand_i;
  pcrel_t     pcrel_offset_i;
  word_t      pc_i;
  reg_index_t wr_index_i;
  logic       stall_o;
  logic       reg_we_o;
  reg_index_t reg_index_o;
  word_t      reg_result_o;
  logic       branch_flag_o;
  word_t      branch_target_o;
  logic       dmem_cyc_o;
  logic       dmem_stb_o;
  logic       dmem_we_o;
  sel_t       dmem_sel_o;
  word_t      dmem_address_o;
  half_t      dmem_data_o;
  logic       dmem_ack_i;
  logic       hold_req;
  int         hold_cnt;
  logic [2:0] delay_cnt;
  logic [15:0] lfsr = 16'd75;
  // LFSR state for the ack delays
  logic [15:0] ack_lfsr = 16'd75;
  int         cycle_cnt = 0;

  moxie_execute #(
    .QUEUE_DEPTH (4)
  ) dut (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .issue_i         (issue_i),
    .op_i            (op_i),
    .reg_a_i         (reg_a_i),
    .reg_b_i         (reg_b_i),
    .operand_i       (operand_i),
    .pcrel_offset_i  (pcrel_offset_i),
    .pc_i            (pc_i),
    .wr_index_i      (wr_index_i),
    .stall_o         (stall_o),
    .reg_we_o        (reg_we_o),
    .reg_index_o     (reg_index_o),
    .reg_result_o    (reg_result_o),
    .branch_flag_o   (branch_flag_o),
    .branch_target_o (branch_target_o),
    .dmem_cyc_o      (dmem_cyc_o),
    .dmem_stb_o      (dmem_stb_o),
    .dmem_we_o       (dmem_we_o),
    .dmem_sel_o      (dmem_sel_o),
    .dmem_address_o  (dmem_address_o),
    .dmem_data_o     (dmem_data_o),
    .dmem_ack_i      (dmem_ack_i)
  );

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic word_t take_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Holds the instruction until the cycle it is accepted
  task automatic send_instr(input opcode_t op);
    word_t a;
    a = take_bits(32);
    issue_i        <= 1'b1;
    op_i           <= op;
    reg_a_i        <= a;
    reg_b_i        <= (take_bits(2) == 0) ? a : take_bits(32);
    operand_i      <= take_bits(32);
    pcrel_offset_i <= pcrel_t'(take_bits(10));
    pc_i           <= take_bits(32);
    wr_index_i     <= reg_index_t'(take_bits(4));
    @(posedge clk_i);
    while (stall_o)
      @(posedge clk_i);
  endtask

  task automatic random_step();
    if (take_bits(3) == 0)
    begin
      issue_i <= 1'b0;
      @(posedge clk_i);
    end
    send_instr(OP_TABLE[take_bits(6) % 40]);
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Data memory: ack after 0 to 5 wait cycles unless held off
  always @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      dmem_ack_i <= 1'b0;
      hold_cnt   <= 0;
      delay_cnt  <= '0;
    end
    else
    begin
      if (hold_req)
        hold_cnt <= HOLD_CYCLES;
      else if (hold_cnt != 0)
        hold_cnt <= hold_cnt - 1;
      if (dmem_ack_i)
        dmem_ack_i <= 1'b0;
      else if (dmem_stb_o && hold_cnt == 0)
      begin
        if (delay_cnt == 0)
        begin
          dmem_ack_i <= 1'b1;
          for (int i = 0; i < 3; i++)
            ack_lfsr = lfsr_next(ack_lfsr);
          delay_cnt  <= ack_lfsr[2:0] % 3'd6;
        end
        else
          delay_cnt <= delay_cnt - 1'b1;
      end
    end
  end

  always @(posedge clk_i)
  begin
    if (dut.u_checks.failed)
    begin
      $display("Something failed");
      $fatal(1, "Stopped at the first failed check");
    end
  end

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Run hung: still busy after %0d cycles", cycle_cnt);
      $display("Something failed");
      $fatal(1, "Cycle limit reached");
    end
  end

  initial
  begin
    rst_i          <= 1'b1;
    issue_i        <= 1'b0;
    op_i           <= '0;
    reg_a_i        <= '0;
    reg_b_i        <= '0;
    operand_i      <= '0;
    pcrel_offset_i <= '0;
    pc_i           <= '0;
    wr_index_i     <= '0;
    hold_req       <= 1'b0;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    for (int i = 0; i < N_RANDOM / 2; i++)
      random_step();
    // Ack withheld while a burst of stores fills the queue
    hold_req <= 1'b1;
    send_instr(OP_TABLE[31 + take_bits(4) % 9]);
    hold_req <= 1'b0;
    for (int i = 1; i < N_HOLD_STORES; i++)
      send_instr(OP_TABLE[31 + take_bits(4) % 9]);
    for (int i = 0; i < N_RANDOM / 2; i++)
      random_step();
    issue_i <= 1'b0;
    // Last accepted store is only counted one edge later
    @(posedge clk_i);
    while (dut.u_checks.exp_count_q != 0 || dmem_stb_o)
      @(posedge clk_i);
    repeat (2) @(posedge clk_i);
    if (dut.u_checks.failed)
    begin
      $display("Something failed");
      $fatal(1, "Checks reported errors");
    end
    else
    begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// File: flist.f
design/moxie_exec_pkg.sv
design/exec_alu.sv
design/store_queue.sv
design/dmem_master.sv
design/moxie_execute.sv
tests/moxie_execute_assertions.sv
tests/moxie_execute_tb.sv

// File: Bender.yml
package:
  name: moxie_execute

sources:
  - design/moxie_exec_pkg.sv
  - design/exec_alu.sv
  - design/store_queue.sv
  - design/dmem_master.sv
  - design/moxie_execute.sv
  - target: test
    files:
      - tests/moxie_execute_assertions.sv
      - tests/moxie_execute_tb.sv
